//--- a09_cpu.f
hw/a09_pkg.sv
hw/a09_alu.sv
hw/a09_regfile.sv
hw/a09_memory.sv
hw/a09_out_port.sv
hw/a09_sequencer.sv
hw/a09_datapath.sv
hw/a09_cpu.sv
bench/a09_cpu_tb.sv

//--- bench/a09_cpu_tb.sv
`timescale 1ns/1ps

module a09_cpu_tb;

    localparam int ADDR_WIDTH  = 8;
    localparam int OUT_CREDITS = 4;
    localparam int DW          = a09_pkg::DATA_WIDTH;

    logic                  clk_i;
    logic                  arst_n_i;
    logic                  run_i;
    logic                  prog_we_i;
    logic [ADDR_WIDTH-1:0] prog_addr_i;
    logic [DW-1:0]         prog_data_i;
    logic                  credit_i;
    logic                  ready_o;
    logic                  halt_o;
    logic                  out_valid_o;
    logic [DW-1:0]         out_data_o;

    logic [DW-1:0] prog [2**ADDR_WIDTH];  // Program image
    int            prog_len     = 0;
    logic [DW-1:0] exp_q[$];              // Reference model outputs
    logic [DW-1:0] got_q[$];              // Seen on the port
    int            due_q[$];              // Cycle each credit goes back
    int            n_checked    = 0;
    int            errors       = 0;
    int            cycle_cnt    = 0;
    int            cycle_limit  = 100;    // Reset and idle margin
    int            port_credits = OUT_CREDITS;
    logic          credit_taken = 1'b0;   // credit_i as seen last cycle
    logic          hold_credits = 1'b0;
    logic [31:0]   rng          = 32'h31d29c62;
    string         test_name    = "reset";

    a09_cpu #(.ADDR_WIDTH(ADDR_WIDTH), .OUT_CREDITS(OUT_CREDITS)) UUT (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .run_i(run_i),
        .prog_we_i(prog_we_i), .prog_addr_i(prog_addr_i), .prog_data_i(prog_data_i),
        .credit_i(credit_i), .ready_o(ready_o), .halt_o(halt_o),
        .out_valid_o(out_valid_o), .out_data_o(out_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [DW-1:0] enc_reg(input a09_pkg::opcode_e op, input logic [2:0] rd,
                                              input logic [2:0] rs1, input logic [2:0] rs2);
        return {op, 3'b000, rd, rs2, rs1};  // Spare bits zero
    endfunction

    function automatic logic [DW-1:0] enc_imm(input a09_pkg::opcode_e op, input logic [2:0] rd,
                                              input logic [7:0] imm);
        return {op, 1'b0, rd, imm};
    endfunction

    function automatic void emit(input logic [DW-1:0] word);
        prog[prog_len] = word;
        prog_len++;
    endfunction

    task automatic stop_on_error(input string what);
        errors++;
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_data(input string name, input logic [DW-1:0] exp,
                              input logic [DW-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s: expected 0x%h, actual 0x%h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            stop_on_error($sformatf("MISMATCH %s output count: expected %0d, actual %0d",
                                    name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // --------------------------------------------------
    // ISA reference model
    // --------------------------------------------------
    function automatic int run_model();
        logic [DW-1:0]         regs [8];
        logic [DW-1:0]         mem  [2**ADDR_WIDTH];
        logic [DW-1:0]         w;
        logic [DW-1:0]         y;
        logic [ADDR_WIDTH-1:0] pc;
        logic [ADDR_WIDTH-1:0] at_pc;
        logic [ADDR_WIDTH-1:0] stk;
        logic                  zero;
        logic [2:0]            rd;
        logic [2:0]            rs1;
        logic [2:0]            rs2;
        a09_pkg::opcode_e      op;
        int                    count;
        for (int i = 0; i < 8; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
            mem[i] = (i < prog_len) ? prog[i] : '0;
        end
        exp_q.delete();
        pc    = '0;
        stk   = '0;
        zero  = 1'b0;
        count = 0;
        while (count < 5000) begin
            at_pc = pc;
            w     = mem[pc];
            op    = a09_pkg::opcode_e'(w[15:12]);
            rd    = w[8:6];
            rs2   = w[5:3];
            rs1   = w[2:0];
            pc    = pc + 1'b1;
            count++;
            y = '0;
            case (op)
                a09_pkg::ADD: y = regs[rs1] + regs[rs2];
                a09_pkg::SUB: y = regs[rs1] - regs[rs2];
                a09_pkg::AND: y = regs[rs1] & regs[rs2];
                a09_pkg::OR:  y = regs[rs1] | regs[rs2];
                a09_pkg::XOR: y = regs[rs1] ^ regs[rs2];
                a09_pkg::OUT: exp_q.push_back(regs[rs1]);
                a09_pkg::LDI: regs[w[10:8]] = {8'h00, w[7:0]};  // Immediate-format rd
                a09_pkg::LD:  regs[rd] = mem[regs[rs2][ADDR_WIDTH-1:0]];
                a09_pkg::ST:  mem[regs[rs2][ADDR_WIDTH-1:0]] = regs[rs1];
                a09_pkg::BNE: begin
                    if (!zero) begin
                        pc = at_pc + w[ADDR_WIDTH-1:0];  // Relative to the BNE itself
                    end
                end
                a09_pkg::JMP: pc = w[ADDR_WIDTH-1:0];
                a09_pkg::JSR: begin
                    stk = pc;
                    pc  = w[ADDR_WIDTH-1:0];
                end
                a09_pkg::RET: pc = stk;
                a09_pkg::HLT: return count;
                default: ;  // NOP
            endcase
            if (w[15:12] >= 4'd1 && w[15:12] <= 4'd5) begin
                regs[rd] = y;
                zero     = (y == '0);
            end
        end
        return count;  // Runaway program, watchdog catches it
    endfunction

    // --------------------------------------------------
    // Programs
    // --------------------------------------------------
    function automatic void build_alu();
        prog_len = 0;
        emit(enc_imm(a09_pkg::LDI, 1, 8'h5A));
        emit(enc_imm(a09_pkg::LDI, 2, 8'h3C));
        emit(enc_imm(a09_pkg::LDI, 3, 8'hFF));
        emit(enc_reg(a09_pkg::ADD, 4, 1, 2));
        emit(enc_reg(a09_pkg::OUT, 0, 4, 0));
        emit(enc_reg(a09_pkg::SUB, 5, 2, 1));  // Wraps negative
        emit(enc_reg(a09_pkg::OUT, 0, 5, 0));
        emit(enc_reg(a09_pkg::AND, 6, 1, 3));
        emit(enc_reg(a09_pkg::OUT, 0, 6, 0));
        emit(enc_reg(a09_pkg::OR, 7, 1, 2));
        emit(enc_reg(a09_pkg::OUT, 0, 7, 0));
        emit(enc_reg(a09_pkg::XOR, 4, 1, 2));
        emit(enc_reg(a09_pkg::OUT, 0, 4, 0));
        emit(enc_reg(a09_pkg::SUB, 5, 1, 1));  // Zero result
        emit(enc_reg(a09_pkg::OUT, 0, 5, 0));
        emit(enc_reg(a09_pkg::HLT, 0, 0, 0));
    endfunction

    function automatic void build_memory();
        prog_len = 0;
        emit(enc_imm(a09_pkg::LDI, 1, 8'h80));  // Data area far from code
        emit(enc_imm(a09_pkg::LDI, 2, 8'h81));
        emit(enc_imm(a09_pkg::LDI, 3, 8'h82));
        emit(enc_imm(a09_pkg::LDI, 4, 8'h11));
        emit(enc_imm(a09_pkg::LDI, 5, 8'h22));
        emit(enc_imm(a09_pkg::LDI, 6, 8'hC3));
        emit(enc_reg(a09_pkg::ADD, 6, 6, 6));   // 16-bit value
        emit(enc_reg(a09_pkg::ST, 0, 4, 1));
        emit(enc_reg(a09_pkg::ST, 0, 5, 2));
        emit(enc_reg(a09_pkg::ST, 0, 6, 3));
        emit(enc_reg(a09_pkg::LD, 7, 0, 1));
        emit(enc_reg(a09_pkg::OUT, 0, 7, 0));
        emit(enc_reg(a09_pkg::LD, 4, 0, 3));
        emit(enc_reg(a09_pkg::OUT, 0, 4, 0));
        emit(enc_reg(a09_pkg::LD, 5, 0, 2));
        emit(enc_reg(a09_pkg::OUT, 0, 5, 0));
        emit(enc_reg(a09_pkg::HLT, 0, 0, 0));
    endfunction

    function automatic void build_control();
        prog_len = 0;
        emit(enc_imm(a09_pkg::LDI, 1, 8'd3));   // 0
        emit(enc_imm(a09_pkg::LDI, 2, 8'd1));   // 1
        emit(enc_reg(a09_pkg::OUT, 0, 1, 0));   // 2 loop head
        emit(enc_reg(a09_pkg::SUB, 1, 1, 2));   // 3
        emit(enc_imm(a09_pkg::BNE, 0, 8'hFE));  // 4 back to 2
        emit(enc_imm(a09_pkg::JSR, 0, 8'd9));   // 5
        emit(enc_imm(a09_pkg::JMP, 0, 8'd12));  // 6
        emit(enc_imm(a09_pkg::LDI, 5, 8'hDD));  // 7 dead
        emit(enc_reg(a09_pkg::OUT, 0, 5, 0));   // 8 dead
        emit(enc_imm(a09_pkg::LDI, 3, 8'h77));  // 9 subroutine
        emit(enc_reg(a09_pkg::OUT, 0, 3, 0));   // 10
        emit(enc_reg(a09_pkg::RET, 0, 0, 0));   // 11
        emit(enc_imm(a09_pkg::LDI, 4, 8'h42));  // 12 jump target
        emit(enc_reg(a09_pkg::OUT, 0, 4, 0));
        emit(enc_reg(a09_pkg::HLT, 0, 0, 0));
    endfunction

    function automatic void build_burst();
        prog_len = 0;
        emit(enc_imm(a09_pkg::LDI, 1, 8'd20));  // Twenty OUTs
        emit(enc_imm(a09_pkg::LDI, 2, 8'd1));
        emit(enc_reg(a09_pkg::OUT, 0, 1, 0));
        emit(enc_reg(a09_pkg::SUB, 1, 1, 2));
        emit(enc_imm(a09_pkg::BNE, 0, 8'hFE));
        emit(enc_reg(a09_pkg::HLT, 0, 0, 0));
    endfunction

    function automatic void build_random();
        logic [31:0]      x;
        a09_pkg::opcode_e op;
        prog_len = 0;
        for (int r = 0; r < 8; r++) begin
            x = next_rand();
            emit(enc_imm(a09_pkg::LDI, r[2:0], x[7:0]));
        end
        for (int n = 0; n < 12; n++) begin
            x  = next_rand();
            op = a09_pkg::opcode_e'(x % 5 + 1);  // ADD to XOR
            emit(enc_reg(op, x[10:8], x[13:11], x[16:14]));
            emit(enc_reg(a09_pkg::OUT, 0, x[10:8], 0));
        end
        emit(enc_reg(a09_pkg::HLT, 0, 0, 0));
    endfunction

    // --------------------------------------------------
    // Load and run
    // --------------------------------------------------
    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk_i);
            #1;
            prog_we_i   = 1'b1;
            prog_addr_i = ADDR_WIDTH'(i);
            prog_data_i = prog[i];
        end
        @(posedge clk_i);
        #1;
        prog_we_i = 1'b0;
    endtask

    task automatic run_program(input string name, input int hold_cycles);
        int n_instr;
        test_name = name;
        n_instr   = run_model();
        n_checked = 0;
        // Per instruction budget plus worst credit delay per output
        cycle_limit = cycle_limit + 20 * n_instr + 8 * exp_q.size() + prog_len
                      + hold_cycles + 50;
        hold_credits = (hold_cycles > 0);
        load_program();
        run_i        = 1'b1;
        repeat (hold_cycles) @(negedge clk_i);
        hold_credits = 1'b0;
        while (!halt_o) begin
            @(negedge clk_i);
        end
        repeat (3) @(negedge clk_i);  // Let the compare loop drain
        check_count(name, exp_q.size(), n_checked);
        check_bit({name, " halt_o"}, 1'b1, halt_o);
        @(posedge clk_i);
        #1;
        run_i = 1'b0;
        @(posedge clk_i);
        @(negedge clk_i);
        check_bit({name, " ready_o"}, 1'b1, ready_o);
        check_bit({name, " halt_o low"}, 1'b0, halt_o);
    endtask

    // --------------------------------------------------
    // Consumer, credit tracking and compare
    // --------------------------------------------------
    always @(negedge clk_i) begin
        if (arst_n_i) begin
            if (out_valid_o) begin
                if (port_credits == 0) begin
                    stop_on_error("out_valid_o pulsed while the port held no credit");
                end
                got_q.push_back(out_data_o);
                due_q.push_back(cycle_cnt + int'(next_rand() % 8));  // 0 to 7 cycles
            end
            port_credits = port_credits + int'(credit_taken) - int'(out_valid_o);
            credit_taken = credit_i;
        end
    end

    initial begin
        credit_i = 1'b0;
        forever begin
            @(posedge clk_i);
            #1;
            if (!hold_credits && due_q.size() > 0 && due_q[0] <= cycle_cnt) begin
                due_q.delete(0);
                credit_i = 1'b1;  // One credit per pulse
            end else begin
                credit_i = 1'b0;
            end
        end
    end

    initial begin
        logic [DW-1:0] word;
        forever begin
            @(negedge clk_i);
            while (got_q.size() > 0) begin
                word = got_q.pop_front();
                if (n_checked >= exp_q.size()) begin
                    stop_on_error($sformatf("Test %s produced an extra output 0x%h",
                                            test_name, word));
                end
                check_data(test_name, exp_q[n_checked], word);
                n_checked++;
            end
        end
    end

    // Watchdog
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            stop_on_error($sformatf("Timeout after %0d cycles in test %s, run did not finish",
                                    cycle_cnt, test_name));
        end
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        arst_n_i    = 1'b0;
        run_i       = 1'b0;
        prog_we_i   = 1'b0;
        prog_addr_i = '0;
        prog_data_i = '0;
        repeat (5) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        @(negedge clk_i);
        check_bit("reset ready_o", 1'b1, ready_o);
        check_bit("reset halt_o", 1'b0, halt_o);
        check_bit("reset out_valid_o", 1'b0, out_valid_o);

        build_alu();
        run_program("alu", 0);
        build_memory();
        run_program("memory", 0);
        build_control();
        run_program("control", 0);
        build_burst();
        run_program("backpressure", 120);  // Credits withheld at first
        build_random();
        run_program("random rerun", 0);

        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- hw/a09_cpu.sv
`timescale 1ns/1ps

module a09_cpu #(
    parameter int ADDR_WIDTH  = 8,
    parameter int OUT_CREDITS = 4
) (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           run_i,
    input  logic                           prog_we_i,
    input  logic [ADDR_WIDTH-1:0]          prog_addr_i,
    input  logic [a09_pkg::DATA_WIDTH-1:0] prog_data_i,
    input  logic                           credit_i,
    output logic                           ready_o,
    output logic                           halt_o,
    output logic                           out_valid_o,
    output logic [a09_pkg::DATA_WIDTH-1:0] out_data_o
);

    // --------------------------------------------------
    // Internal nets
    // --------------------------------------------------
    a09_pkg::ctrl_t                 ctrl;
    a09_pkg::instr_u                instr;
    a09_pkg::flags_t                flags;
    a09_pkg::flags_t                alu_flags;
    logic                           has_credit;
    logic [ADDR_WIDTH-1:0]          mem_addr;
    logic [2:0]                     rd;
    logic [2:0]                     rs1;
    logic [2:0]                     rs2;
    logic [a09_pkg::DATA_WIDTH-1:0] reg_wdata;
    logic [a09_pkg::DATA_WIDTH-1:0] src1;
    logic [a09_pkg::DATA_WIDTH-1:0] src2;
    logic [a09_pkg::DATA_WIDTH-1:0] mem_rdata;
    logic [a09_pkg::DATA_WIDTH-1:0] alu_y;

    a09_sequencer u_seq (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .run_i(run_i),
        .instr_i(instr), .flags_i(flags), .has_credit_i(has_credit),
        .ctrl_o(ctrl), .ready_o(ready_o), .halt_o(halt_o)
    );

    // PC pinned to 0 while idle
    a09_datapath #(.ADDR_WIDTH(ADDR_WIDTH)) u_dp (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .ctrl_i(ctrl), .start_i(ready_o),
        .mem_data_i(mem_rdata), .alu_y_i(alu_y), .src1_i(src1),
        .alu_flags_i(alu_flags), .instr_o(instr), .flags_o(flags),
        .addr_o(mem_addr), .rd_o(rd), .rs1_o(rs1), .rs2_o(rs2), .wdata_o(reg_wdata)
    );

    a09_regfile u_rf (
        .clk_i(clk_i), .we_i(ctrl.reg_we), .rd_i(rd), .rs1_i(rs1), .rs2_i(rs2),
        .wdata_i(reg_wdata), .src1_o(src1), .src2_o(src2)
    );

    a09_alu u_alu (
        .a_i(src1), .b_i(src2), .op_i(instr.fmt_reg.opcode),  // Opcode is ALU op
        .y_o(alu_y), .flags_o(alu_flags)
    );

    // Store data on source 2 since the datapath swaps ports for ST
    a09_memory #(.ADDR_WIDTH(ADDR_WIDTH)) u_mem (
        .clk_i(clk_i), .addr_i(mem_addr), .we_i(ctrl.mem_wr), .wdata_i(src2),
        .prog_we_i(prog_we_i), .prog_addr_i(prog_addr_i), .prog_data_i(prog_data_i),
        .rdata_o(mem_rdata)
    );

    a09_out_port #(.OUT_CREDITS(OUT_CREDITS)) u_out (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .ld_i(ctrl.out_ld), .data_i(src1),
        .credit_i(credit_i), .has_credit_o(has_credit),
        .out_valid_o(out_valid_o), .out_data_o(out_data_o)
    );

endmodule

//--- hw/a09_datapath.sv
`timescale 1ns/1ps

module a09_datapath #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                             clk_i,
    input  logic                             arst_n_i,
    input  a09_pkg::ctrl_t                   ctrl_i,
    input  logic                             start_i,
    input  logic [a09_pkg::DATA_WIDTH-1:0]   mem_data_i,
    input  logic [a09_pkg::DATA_WIDTH-1:0]   alu_y_i,
    input  logic [a09_pkg::DATA_WIDTH-1:0]   src1_i,
    input  a09_pkg::flags_t                  alu_flags_i,
    output a09_pkg::instr_u                  instr_o,
    output a09_pkg::flags_t                  flags_o,
    output logic [ADDR_WIDTH-1:0]            addr_o,
    output logic [2:0]                       rd_o,
    output logic [2:0]                       rs1_o,
    output logic [2:0]                       rs2_o,
    output logic [a09_pkg::DATA_WIDTH-1:0]   wdata_o
);

    logic [ADDR_WIDTH-1:0]          pc_q;
    logic [ADDR_WIDTH-1:0]          pc_d;
    logic [ADDR_WIDTH-1:0]          pc_mux;
    logic [ADDR_WIDTH-1:0]          stk_q;
    logic [a09_pkg::DATA_WIDTH-1:0] imm_zx;
    logic [a09_pkg::DATA_WIDTH-1:0] imm_sx;
    logic [a09_pkg::DATA_WIDTH-1:0] alu_q;
    a09_pkg::instr_u                ir_q;
    a09_pkg::flags_t                flg_q;
    a09_pkg::opcode_e               opcode;
    logic                           mem_op;

    assign opcode  = ir_q.fmt_reg.opcode;
    assign instr_o = ir_q;
    assign flags_o = flg_q;

    // --------------------------------------------------
    // Immediates and PC selection
    // --------------------------------------------------
    assign imm_zx = {{(a09_pkg::DATA_WIDTH-8){1'b0}}, ir_q.fmt_imm.imm};
    assign imm_sx = {{(a09_pkg::DATA_WIDTH-8){ir_q.fmt_imm.imm[7]}}, ir_q.fmt_imm.imm};

    always_comb begin
        case (ctrl_i.pc_src)
            a09_pkg::PC_BRA: pc_mux = pc_q - 1'b1 + imm_sx[ADDR_WIDTH-1:0];  // PC is one ahead
            a09_pkg::PC_RET: pc_mux = stk_q;
            a09_pkg::PC_ABS: pc_mux = imm_zx[ADDR_WIDTH-1:0];
            default:         pc_mux = pc_q + 1'b1;
        endcase
    end

    // Next PC also addresses memory so the read lands in fetch
    assign pc_d = start_i ? '0 : (ctrl_i.pc_ld ? pc_mux : pc_q);
    assign addr_o = (ctrl_i.addr_src == a09_pkg::ADDR_SRC2) ? src1_i[ADDR_WIDTH-1:0] : pc_d;

    // LD/ST swap read ports so the address rides on source 1
    assign mem_op = (opcode == a09_pkg::LD) || (opcode == a09_pkg::ST);
    assign rs1_o  = mem_op ? ir_q.fmt_reg.rs2 : ir_q.fmt_reg.rs1;
    assign rs2_o  = mem_op ? ir_q.fmt_reg.rs1 : ir_q.fmt_reg.rs2;
    assign rd_o   = (opcode == a09_pkg::LDI) ? ir_q.fmt_imm.rd : ir_q.fmt_reg.rd;

    always_comb begin
        case (ctrl_i.data_src)
            a09_pkg::DATA_MEM: wdata_o = mem_data_i;
            a09_pkg::DATA_ALU: wdata_o = alu_q;
            default:           wdata_o = imm_zx;
        endcase
    end

    // --------------------------------------------------
    // Registers
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q  <= '0;
            ir_q  <= '0;  // Decodes as NOP
            flg_q <= '0;
        end else begin
            pc_q <= pc_d;
            if (ctrl_i.ir_ld) begin
                ir_q <= mem_data_i;
            end
            if (ctrl_i.flg_ld) begin
                flg_q <= alu_flags_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctrl_i.stk_ld) begin
            stk_q <= pc_q;  // One-entry return stack
        end
        if (ctrl_i.alu_ld) begin
            alu_q <= alu_y_i;
        end
    end

    // Fetch only ever increments the PC
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ctrl_i.ir_ld |-> (pc_d == pc_q + 1'b1));

endmodule

//--- hw/a09_sequencer.sv
`timescale 1ns/1ps

module a09_sequencer (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             run_i,
    input  a09_pkg::instr_u  instr_i,
    input  a09_pkg::flags_t  flags_i,
    input  logic             has_credit_i,
    output a09_pkg::ctrl_t   ctrl_o,
    output logic             ready_o,
    output logic             halt_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_EXEC,
        S_WB,
        S_HALT
    } state_e;

    state_e           state_q;
    state_e           state_d;
    a09_pkg::opcode_e opcode;

    assign opcode  = instr_i.fmt_reg.opcode;
    assign ready_o = (state_q == S_IDLE);
    assign halt_o  = (state_q == S_HALT);  // Held until run_i drops

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------------------------------------
    // Sequence control matrix
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        ctrl_o  = '0;
        case (state_q)
            S_IDLE: begin
                if (run_i) begin
                    state_d = S_FETCH;  // PC held at 0 while idle
                end
            end
            S_FETCH: begin
                ctrl_o.ir_ld  = 1'b1;
                ctrl_o.pc_ld  = 1'b1;
                ctrl_o.pc_src = a09_pkg::PC_INC;
                state_d       = S_DECODE;
            end
            S_DECODE: begin
                state_d = S_EXEC;
            end
            S_EXEC: begin
                state_d = S_FETCH;
                case (opcode)
                    a09_pkg::ADD, a09_pkg::SUB, a09_pkg::AND,
                    a09_pkg::OR, a09_pkg::XOR: begin
                        ctrl_o.alu_ld = 1'b1;
                        ctrl_o.flg_ld = 1'b1;
                        state_d       = S_WB;
                    end
                    a09_pkg::OUT: begin
                        if (has_credit_i) begin
                            ctrl_o.out_ld = 1'b1;
                        end else begin
                            state_d = S_EXEC;  // Wait for the consumer
                        end
                    end
                    a09_pkg::LDI: begin
                        state_d = S_WB;
                    end
                    a09_pkg::LD: begin
                        ctrl_o.addr_src = a09_pkg::ADDR_SRC2;  // Data ready in WB
                        state_d         = S_WB;
                    end
                    a09_pkg::ST: begin
                        ctrl_o.addr_src = a09_pkg::ADDR_SRC2;
                        ctrl_o.mem_wr   = 1'b1;
                    end
                    a09_pkg::BNE: begin
                        if (!flags_i.zero) begin
                            ctrl_o.pc_ld  = 1'b1;
                            ctrl_o.pc_src = a09_pkg::PC_BRA;
                        end
                    end
                    a09_pkg::JMP: begin
                        ctrl_o.pc_ld  = 1'b1;
                        ctrl_o.pc_src = a09_pkg::PC_ABS;
                    end
                    a09_pkg::JSR: begin
                        ctrl_o.stk_ld = 1'b1;  // PC already points past JSR
                        ctrl_o.pc_ld  = 1'b1;
                        ctrl_o.pc_src = a09_pkg::PC_ABS;
                    end
                    a09_pkg::RET: begin
                        ctrl_o.pc_ld  = 1'b1;
                        ctrl_o.pc_src = a09_pkg::PC_RET;
                    end
                    a09_pkg::HLT: begin
                        state_d = S_HALT;
                    end
                    default: begin
                        state_d = S_FETCH;  // NOP and unused code
                    end
                endcase
            end
            S_WB: begin
                ctrl_o.reg_we = 1'b1;
                case (opcode)
                    a09_pkg::LD:  ctrl_o.data_src = a09_pkg::DATA_MEM;
                    a09_pkg::LDI: ctrl_o.data_src = a09_pkg::DATA_IMM;
                    default:      ctrl_o.data_src = a09_pkg::DATA_ALU;
                endcase
                state_d = S_FETCH;
            end
            S_HALT: begin
                state_d = S_HALT;
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
        // Dropping run aborts from any state
        if (!run_i) begin
            state_d = S_IDLE;
        end
    end

    // Memory and register file never written together
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(ctrl_o.mem_wr && ctrl_o.reg_we));

endmodule

//--- hw/a09_out_port.sv
`timescale 1ns/1ps

module a09_out_port #(
    parameter int OUT_CREDITS = 4
) (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           ld_i,
    input  logic [a09_pkg::DATA_WIDTH-1:0] data_i,
    input  logic                           credit_i,
    output logic                           has_credit_o,
    output logic                           out_valid_o,
    output logic [a09_pkg::DATA_WIDTH-1:0] out_data_o
);

    localparam int CW = $clog2(OUT_CREDITS + 1);

    logic [CW-1:0] cnt_q;  // Credits held on our side

    assign has_credit_o = (cnt_q != '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q       <= CW'(OUT_CREDITS);
            out_valid_o <= 1'b0;
        end else begin
            cnt_q       <= cnt_q + CW'(credit_i) - CW'(ld_i);  // Spend and return
            out_valid_o <= ld_i;                              // One-cycle pulse
        end
    end

    always_ff @(posedge clk_i) begin
        if (ld_i) begin
            out_data_o <= data_i;
        end
    end

    // Consumer never over-returns
    assert property (@(posedge clk_i) disable iff (!arst_n_i) cnt_q <= CW'(OUT_CREDITS));
    // Sequencer holds OUT while empty
    assert property (@(posedge clk_i) disable iff (!arst_n_i) ld_i |-> cnt_q != '0);

endmodule

//--- hw/a09_memory.sv
`timescale 1ns/1ps

module a09_memory #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                           clk_i,
    input  logic [ADDR_WIDTH-1:0]          addr_i,
    input  logic                           we_i,
    input  logic [a09_pkg::DATA_WIDTH-1:0] wdata_i,
    input  logic                           prog_we_i,
    input  logic [ADDR_WIDTH-1:0]          prog_addr_i,
    input  logic [a09_pkg::DATA_WIDTH-1:0] prog_data_i,
    output logic [a09_pkg::DATA_WIDTH-1:0] rdata_o
);

    logic [a09_pkg::DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    always_ff @(posedge clk_i) begin
        if (prog_we_i) begin
            mem[prog_addr_i] <= prog_data_i;  // Program load while idle
        end else if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        // Read register keeps its word during a CPU write
        if (!we_i) begin
            rdata_o <= mem[addr_i];
        end
    end

    // Loader only runs while the CPU is idle
    assert property (@(posedge clk_i) !(we_i && prog_we_i));

endmodule

//--- hw/a09_regfile.sv
`timescale 1ns/1ps

module a09_regfile (
    input  logic                           clk_i,
    input  logic                           we_i,
    input  logic [2:0]                     rd_i,
    input  logic [2:0]                     rs1_i,
    input  logic [2:0]                     rs2_i,
    input  logic [a09_pkg::DATA_WIDTH-1:0] wdata_i,
    output logic [a09_pkg::DATA_WIDTH-1:0] src1_o,
    output logic [a09_pkg::DATA_WIDTH-1:0] src2_o
);

    logic [a09_pkg::DATA_WIDTH-1:0] regs [8];  // Set up by LDI

    // Two asynchronous read ports
    assign src1_o = regs[rs1_i];
    assign src2_o = regs[rs2_i];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            regs[rd_i] <= wdata_i;
        end
    end

endmodule

//--- hw/a09_alu.sv
`timescale 1ns/1ps

module a09_alu (
    input  logic [a09_pkg::DATA_WIDTH-1:0] a_i,
    input  logic [a09_pkg::DATA_WIDTH-1:0] b_i,
    input  a09_pkg::opcode_e               op_i,
    output logic [a09_pkg::DATA_WIDTH-1:0] y_o,
    output a09_pkg::flags_t                flags_o
);

    localparam int MSB = a09_pkg::DATA_WIDTH - 1;

    logic [a09_pkg::DATA_WIDTH:0] sum;  // Extra bit is carry out

    always_comb begin
        sum              = '0;
        flags_o.carry    = 1'b0;
        flags_o.overflow = 1'b0;
        case (op_i)
            a09_pkg::ADD: begin
                sum              = {1'b0, a_i} + {1'b0, b_i};
                flags_o.carry    = sum[a09_pkg::DATA_WIDTH];
                flags_o.overflow = (a_i[MSB] == b_i[MSB]) && (sum[MSB] != a_i[MSB]);
            end
            a09_pkg::SUB: begin
                sum              = {1'b0, a_i} - {1'b0, b_i};
                flags_o.carry    = sum[a09_pkg::DATA_WIDTH];  // Borrow
                flags_o.overflow = (a_i[MSB] != b_i[MSB]) && (sum[MSB] != a_i[MSB]);
            end
            a09_pkg::AND: sum[MSB:0] = a_i & b_i;
            a09_pkg::OR:  sum[MSB:0] = a_i | b_i;
            a09_pkg::XOR: sum[MSB:0] = a_i ^ b_i;
            default:      sum = '0;
        endcase
        y_o              = sum[MSB:0];
        flags_o.zero     = (y_o == '0);
        flags_o.negative = y_o[MSB];
    end

endmodule

//--- hw/a09_pkg.sv
package a09_pkg;

    // Data path width, tied to the 16-bit instruction word
    localparam int DATA_WIDTH = 16;

    // --------------------------------------------------
    // Opcodes
    // --------------------------------------------------
    // ALU operation is taken straight from the opcode
    typedef enum logic [3:0] {
        NOP = 4'd0,
        ADD = 4'd1,
        SUB = 4'd2,
        AND = 4'd3,
        OR  = 4'd4,
        XOR = 4'd5,
        OUT = 4'd6,   // Source 1 to output port
        LDI = 4'd8,   // Zero-extended immediate
        LD  = 4'd9,   // Address in source 2
        ST  = 4'd10,
        BNE = 4'd11,  // PC relative
        JMP = 4'd12,
        JSR = 4'd13,
        RET = 4'd14,
        HLT = 4'd15
    } opcode_e;

    // --------------------------------------------------
    // Instruction formats
    // --------------------------------------------------
    typedef struct packed {
        opcode_e    opcode;   // [15:12]
        logic       spare_hi; // [11]
        logic [1:0] spare_lo; // [10:9]
        logic [2:0] rd;       // [8:6]
        logic [2:0] rs2;      // [5:3]
        logic [2:0] rs1;      // [2:0]
    } instr_reg_t;

    typedef struct packed {
        opcode_e    opcode;
        logic       spare;
        logic [2:0] rd;       // [10:8] LDI destination
        logic [7:0] imm;
    } instr_imm_t;

    // Same word seen through either format
    typedef union packed {
        instr_reg_t fmt_reg;
        instr_imm_t fmt_imm;
    } instr_u;

    typedef struct packed {
        logic zero;
        logic carry;
        logic negative;
        logic overflow;
    } flags_t;

    // --------------------------------------------------
    // Control matrix
    // --------------------------------------------------
    typedef enum logic [1:0] {PC_INC, PC_BRA, PC_RET, PC_ABS} pc_src_e;
    typedef enum logic {ADDR_PC, ADDR_SRC2} addr_src_e;
    typedef enum logic [1:0] {DATA_IMM, DATA_MEM, DATA_ALU} data_src_e;

    typedef struct packed {
        logic      ir_ld;
        logic      pc_ld;
        pc_src_e   pc_src;
        logic      stk_ld;   // Save return PC
        addr_src_e addr_src;
        logic      mem_wr;
        logic      reg_we;
        data_src_e data_src;
        logic      alu_ld;
        logic      flg_ld;
        logic      out_ld;
    } ctrl_t;

endpackage
